//--- design/game_pkg.sv
package game_pkg;

    typedef logic [9:0]  coord_t;
    typedef logic [11:0] color_t;
    typedef logic [3:0]  speed_t;
    typedef logic [3:0]  inv_idx_t;

    // one frame update walks these in order
    typedef enum logic [2:0] {
        IDLE,
        CHECK,
        MOVE,
        COLLIDE,
        SHOOT
    } phase_t;

    // formation, 4 rows of 4
    localparam int N_INV     = 16;
    localparam int FIELD_W   = 640;
    localparam int FIELD_H   = 480;
    localparam int INV_SIZE  = 16;
    localparam int INV_X0    = 32;
    localparam int INV_Y0    = 32;
    localparam int INV_DX    = 32;
    localparam int INV_DY    = 48;
    localparam int DROP_STEP = 8;
    localparam int INV_FLOOR = 400;

    // player cannon and its shot
    localparam int CANNON_V    = 440;
    localparam int CANNON_W    = 16;
    localparam int CANNON_H    = 8;
    localparam int CANNON_X0   = 312;
    localparam int CANNON_STEP = 2;
    localparam int CANNON_MAX  = 624;
    localparam int LASER_LEN   = 8;
    localparam int LASER_STEP  = 4;

    localparam color_t ROW_COLOR [4] = '{12'hf0f, 12'h0ff, 12'h0f0, 12'hf80};
    localparam color_t CANNON_COLOR  = 12'hff0;
    localparam color_t LASER_COLOR   = 12'hfff;
    localparam color_t BG_COLOR      = 12'h000;

    // scan in to colour out
    localparam int PIXEL_LATENCY = 2;

endpackage

//--- design/laser_if.sv
`timescale 1ns/1ps

interface laser_if;

    logic             active;
    game_pkg::coord_t laser_h;
    game_pkg::coord_t laser_v;
    // kill report, one cycle during COLLIDE
    logic             hit;

    modport shooter (output active, output laser_h, output laser_v, input hit);
    modport target  (input active, input laser_h, input laser_v, output hit);
    modport view    (input active, input laser_h, input laser_v);

endinterface

//--- design/frame_sequencer.sv
`timescale 1ns/1ps

module frame_sequencer (
    input  logic                clk25M,
    input  logic                reset,
    input  logic                frame_tick,
    output game_pkg::phase_t    phase,
    output game_pkg::inv_idx_t  index,
    output logic                busy
);

    logic last;

    assign last = (index == game_pkg::inv_idx_t'(game_pkg::N_INV - 1));
    assign busy = (phase != game_pkg::IDLE);

    always_ff @(posedge clk25M) begin
        if (reset) begin
            phase <= game_pkg::IDLE;
            index <= '0;
        end else begin
            case (phase)
                game_pkg::IDLE: begin
                    if (frame_tick) begin
                        phase <= game_pkg::CHECK;
                    end
                end
                game_pkg::CHECK: begin
                    index <= last ? '0 : index + 1'b1;
                    if (last) begin
                        phase <= game_pkg::MOVE;
                    end
                end
                game_pkg::MOVE: begin
                    index <= last ? '0 : index + 1'b1;
                    if (last) begin
                        phase <= game_pkg::COLLIDE;
                    end
                end
                game_pkg::COLLIDE: begin
                    index <= last ? '0 : index + 1'b1;
                    if (last) begin
                        phase <= game_pkg::SHOOT;
                    end
                end
                default: begin
                    // single SHOOT cycle
                    phase <= game_pkg::IDLE;
                end
            endcase
        end
    end

endmodule

//--- design/invader_formation.sv
`timescale 1ns/1ps

module invader_formation (
    input  logic                      clk25M,
    input  logic                      reset,
    input  game_pkg::phase_t          phase,
    input  game_pkg::inv_idx_t        index,
    input  game_pkg::speed_t          speed,
    laser_if.target                   laser,
    output logic [game_pkg::N_INV-1:0] alive,
    output game_pkg::coord_t          inv_h [game_pkg::N_INV],
    output game_pkg::coord_t          inv_v [game_pkg::N_INV]
);

    game_pkg::coord_t cur_h;
    game_pkg::coord_t cur_v;
    logic [10:0]      right_edge;
    logic             wall_hit;
    logic             overlap;
    logic             dir_right;
    logic             wall_flag;
    logic             floor_flag;

    assign cur_h = inv_h[index];
    assign cur_v = inv_v[index];

    // wall test for the invader under the sweep
    assign right_edge = 11'(cur_h) + 11'(game_pkg::INV_SIZE) + 11'(speed);
    assign wall_hit   = dir_right ? (right_edge > 11'(game_pkg::FIELD_W))
                                  : (cur_h < game_pkg::coord_t'(speed));

    // laser column inside the box and laser span meets the box rows
    assign overlap = (laser.laser_h >= cur_h)
                  && (11'(laser.laser_h) < 11'(cur_h) + 11'(game_pkg::INV_SIZE))
                  && (11'(laser.laser_v) < 11'(cur_v) + 11'(game_pkg::INV_SIZE))
                  && (11'(cur_v) < 11'(laser.laser_v) + 11'(game_pkg::LASER_LEN));

    // sweep runs upward, so the first hit is the lowest index
    assign laser.hit = (phase == game_pkg::COLLIDE) && alive[index]
                    && laser.active && overlap;

    always_ff @(posedge clk25M) begin
        if (reset) begin
            for (int i = 0; i < game_pkg::N_INV; i++) begin
                inv_h[i] <= game_pkg::coord_t'(game_pkg::INV_X0 + (i % 4) * game_pkg::INV_DX);
                inv_v[i] <= game_pkg::coord_t'(game_pkg::INV_Y0 + (i / 4) * game_pkg::INV_DY);
            end
            alive      <= '1;
            dir_right  <= 1'b1;
            wall_flag  <= 1'b0;
            floor_flag <= 1'b0;
        end else begin
            case (phase)
                game_pkg::IDLE: begin
                    wall_flag  <= 1'b0;
                    floor_flag <= 1'b0;
                end
                game_pkg::CHECK: begin
                    if (alive[index]) begin
                        if (wall_hit) begin
                            wall_flag <= 1'b1;
                        end
                        if (cur_v >= game_pkg::coord_t'(game_pkg::INV_FLOOR)) begin
                            floor_flag <= 1'b1;
                        end
                    end
                end
                game_pkg::MOVE: begin
                    if (alive[index]) begin
                        if (wall_flag) begin
                            if (!floor_flag) begin
                                inv_v[index] <= cur_v + game_pkg::coord_t'(game_pkg::DROP_STEP);
                            end
                        end else if (dir_right) begin
                            inv_h[index] <= cur_h + game_pkg::coord_t'(speed);
                        end else begin
                            inv_h[index] <= cur_h - game_pkg::coord_t'(speed);
                        end
                    end
                    // reverse once the whole row set has stepped
                    if (wall_flag && index == game_pkg::inv_idx_t'(game_pkg::N_INV - 1)) begin
                        dir_right <= !dir_right;
                    end
                end
                game_pkg::COLLIDE: begin
                    if (laser.hit) begin
                        alive[index] <= 1'b0;
                    end
                end
                default: begin
                end
            endcase
        end
    end

endmodule

//--- design/cannon_laser.sv
`timescale 1ns/1ps

module cannon_laser (
    input  logic              clk25M,
    input  logic              reset,
    input  logic              btn_left,
    input  logic              btn_right,
    input  logic              btn_fire,
    input  game_pkg::phase_t  phase,
    laser_if.shooter          laser,
    output game_pkg::coord_t  cannon_h
);

    logic shoot;

    assign shoot = (phase == game_pkg::SHOOT);

    // cannon, left wins over right
    always_ff @(posedge clk25M) begin
        if (reset) begin
            cannon_h <= game_pkg::coord_t'(game_pkg::CANNON_X0);
        end else if (shoot) begin
            if (btn_left && cannon_h >= game_pkg::coord_t'(game_pkg::CANNON_STEP)) begin
                cannon_h <= cannon_h - game_pkg::coord_t'(game_pkg::CANNON_STEP);
            end else if (btn_right && cannon_h < game_pkg::coord_t'(game_pkg::CANNON_MAX)) begin
                cannon_h <= cannon_h + game_pkg::coord_t'(game_pkg::CANNON_STEP);
            end
        end
    end

    always_ff @(posedge clk25M) begin
        if (reset) begin
            laser.active <= 1'b0;
        end else if (laser.hit) begin
            laser.active <= 1'b0;
        end else if (shoot) begin
            if (laser.active) begin
                if (laser.laser_v < game_pkg::coord_t'(game_pkg::LASER_STEP)) begin
                    laser.active <= 1'b0;
                end
            end else if (btn_fire) begin
                laser.active <= 1'b1;
            end
        end
    end

    // shot position, meaningful only while active
    always_ff @(posedge clk25M) begin
        if (shoot) begin
            if (laser.active) begin
                laser.laser_v <= laser.laser_v - game_pkg::coord_t'(game_pkg::LASER_STEP);
            end else if (btn_fire) begin
                laser.laser_v <= game_pkg::coord_t'(game_pkg::CANNON_V - game_pkg::LASER_LEN);
                // spawns above the centre of the old cannon position
                laser.laser_h <= cannon_h + game_pkg::coord_t'(game_pkg::CANNON_W / 2);
            end
        end
    end

endmodule

//--- design/pixel_renderer.sv
`timescale 1ns/1ps

module pixel_renderer (
    input  logic                       clk25M,
    input  logic                       reset,
    input  logic                       scan_en,
    input  game_pkg::coord_t           scan_h,
    input  game_pkg::coord_t           scan_v,
    input  logic [game_pkg::N_INV-1:0] alive,
    input  game_pkg::coord_t           inv_h [game_pkg::N_INV],
    input  game_pkg::coord_t           inv_v [game_pkg::N_INV],
    input  game_pkg::coord_t           cannon_h,
    laser_if.view                      laser,
    output logic                       pixel_en,
    output game_pkg::color_t           pixel_color
);

    logic [game_pkg::N_INV-1:0]       inv_hit;
    game_pkg::inv_idx_t               inv_sel;
    logic                             laser_hit;
    logic                             cannon_hit;
    logic                             laser_q;
    logic                             cannon_q;
    logic                             inv_q;
    logic [1:0]                       row_q;
    logic [game_pkg::PIXEL_LATENCY-1:0] en_pipe;

    always_comb begin
        for (int i = 0; i < game_pkg::N_INV; i++) begin
            inv_hit[i] = alive[i]
                      && (scan_h >= inv_h[i])
                      && (11'(scan_h) < 11'(inv_h[i]) + 11'(game_pkg::INV_SIZE))
                      && (scan_v >= inv_v[i])
                      && (11'(scan_v) < 11'(inv_v[i]) + 11'(game_pkg::INV_SIZE));
        end
    end

    // lowest index wins
    always_comb begin
        inv_sel = '0;
        for (int i = game_pkg::N_INV - 1; i >= 0; i--) begin
            if (inv_hit[i]) begin
                inv_sel = game_pkg::inv_idx_t'(i);
            end
        end
    end

    assign laser_hit = laser.active && (scan_h == laser.laser_h)
                    && (scan_v >= laser.laser_v)
                    && (11'(scan_v) < 11'(laser.laser_v) + 11'(game_pkg::LASER_LEN));

    assign cannon_hit = (scan_h >= cannon_h)
                     && (11'(scan_h) < 11'(cannon_h) + 11'(game_pkg::CANNON_W))
                     && (scan_v >= game_pkg::coord_t'(game_pkg::CANNON_V))
                     && (scan_v < game_pkg::coord_t'(game_pkg::CANNON_V + game_pkg::CANNON_H));

    // stage 1
    always_ff @(posedge clk25M) begin
        laser_q  <= laser_hit;
        cannon_q <= cannon_hit;
        inv_q    <= |inv_hit;
        // row is index / 4
        row_q    <= inv_sel[3:2];
    end

    // stage 2
    always_ff @(posedge clk25M) begin
        if (laser_q) begin
            pixel_color <= game_pkg::LASER_COLOR;
        end else if (cannon_q) begin
            pixel_color <= game_pkg::CANNON_COLOR;
        end else if (inv_q) begin
            pixel_color <= game_pkg::ROW_COLOR[row_q];
        end else begin
            pixel_color <= game_pkg::BG_COLOR;
        end
    end

    always_ff @(posedge clk25M) begin
        if (reset) begin
            en_pipe <= '0;
        end else begin
            en_pipe <= {en_pipe[game_pkg::PIXEL_LATENCY-2:0], scan_en};
        end
    end

    assign pixel_en = en_pipe[game_pkg::PIXEL_LATENCY-1];

endmodule

//--- design/game_top.sv
`timescale 1ns/1ps

module game_top (
    input  logic              clk25M,
    input  logic              reset,
    input  logic              frame_tick,
    input  logic              btn_left,
    input  logic              btn_right,
    input  logic              btn_fire,
    input  game_pkg::speed_t  speed,
    input  logic              scan_en,
    input  game_pkg::coord_t  scan_h,
    input  game_pkg::coord_t  scan_v,
    output logic              busy,
    output logic              pixel_en,
    output game_pkg::color_t  pixel_color
);

    game_pkg::phase_t           phase;
    game_pkg::inv_idx_t         index;
    logic [game_pkg::N_INV-1:0] alive;
    game_pkg::coord_t           inv_h [game_pkg::N_INV];
    game_pkg::coord_t           inv_v [game_pkg::N_INV];
    game_pkg::coord_t           cannon_h;

    laser_if u_laser ();

    frame_sequencer u_seq (
        .clk25M     (clk25M),
        .reset      (reset),
        .frame_tick (frame_tick),
        .phase      (phase),
        .index      (index),
        .busy       (busy)
    );

    invader_formation u_formation (
        .clk25M (clk25M),
        .reset  (reset),
        .phase  (phase),
        .index  (index),
        .speed  (speed),
        .laser  (u_laser.target),
        .alive  (alive),
        .inv_h  (inv_h),
        .inv_v  (inv_v)
    );

    cannon_laser u_cannon (
        .clk25M    (clk25M),
        .reset     (reset),
        .btn_left  (btn_left),
        .btn_right (btn_right),
        .btn_fire  (btn_fire),
        .phase     (phase),
        .laser     (u_laser.shooter),
        .cannon_h  (cannon_h)
    );

    pixel_renderer u_render (
        .clk25M      (clk25M),
        .reset       (reset),
        .scan_en     (scan_en),
        .scan_h      (scan_h),
        .scan_v      (scan_v),
        .alive       (alive),
        .inv_h       (inv_h),
        .inv_v       (inv_v),
        .cannon_h    (cannon_h),
        .laser       (u_laser.view),
        .pixel_en    (pixel_en),
        .pixel_color (pixel_color)
    );

endmodule

//--- test/game_checker.sv
`timescale 1ns/1ps

module game_checker (
    input logic clk25M,
    input logic reset,
    input logic frame_tick,
    input logic busy,
    input logic scan_en,
    input logic pixel_en
);

    localparam int BUSY_CYCLES = 3 * game_pkg::N_INV + 1;

    int busy_len;

    // length of the current busy stretch
    always_ff @(posedge clk25M) begin
        if (reset || !busy) begin
            busy_len <= 0;
        end else begin
            busy_len <= busy_len + 1;
        end
    end

    a_busy_start: assert property (@(posedge clk25M) disable iff (reset)
        (frame_tick && !busy) |=> busy)
        else $error("busy did not rise after an idle frame tick");

    a_busy_cause: assert property (@(posedge clk25M) disable iff (reset)
        $rose(busy) |-> $past(frame_tick))
        else $error("busy rose without a frame tick");

    a_busy_len: assert property (@(posedge clk25M) disable iff (reset)
        $fell(busy) |-> (busy_len == BUSY_CYCLES))
        else $error("busy lasted %0d cycles", busy_len);

    a_pixel_lag: assert property (@(posedge clk25M) disable iff (reset)
        pixel_en == $past(scan_en, game_pkg::PIXEL_LATENCY))
        else $error("pixel_en does not follow scan_en");

    a_reset_quiet: assert property (@(posedge clk25M)
        reset |=> (!busy && !pixel_en))
        else $error("busy or pixel_en high after reset");

endmodule

//--- test/game_model.svh
`ifndef GAME_MODEL_SVH
`define GAME_MODEL_SVH

// reference picture state, advanced once per frame
int ref_h [game_pkg::N_INV];
int ref_v [game_pkg::N_INV];
bit ref_alive [game_pkg::N_INV];
bit ref_right;
int ref_cannon;
bit ref_shot;
int ref_shot_h;
int ref_shot_v;

function automatic void reset_model();
    for (int i = 0; i < game_pkg::N_INV; i++) begin
        ref_h[i] = game_pkg::INV_X0 + (i % 4) * game_pkg::INV_DX;
        ref_v[i] = game_pkg::INV_Y0 + (i / 4) * game_pkg::INV_DY;
        ref_alive[i] = 1'b1;
    end
    ref_right = 1'b1;
    ref_cannon = game_pkg::CANNON_X0;
    ref_shot = 1'b0;
    ref_shot_h = 0;
    ref_shot_v = 0;
endfunction

// march, then collide, then cannon and shot
function automatic void step_frame(input bit left, input bit right, input bit fire,
                                   input int spd);
    bit wall;
    bit floor_hit;
    bit hit;
    int old_cannon;
    wall = 1'b0;
    floor_hit = 1'b0;
    hit = 1'b0;
    old_cannon = ref_cannon;
    for (int i = 0; i < game_pkg::N_INV; i++) begin
        if (ref_alive[i]) begin
            if (ref_right && ref_h[i] + game_pkg::INV_SIZE + spd > game_pkg::FIELD_W) begin
                wall = 1'b1;
            end
            if (!ref_right && ref_h[i] < spd) begin
                wall = 1'b1;
            end
            if (ref_v[i] >= game_pkg::INV_FLOOR) begin
                floor_hit = 1'b1;
            end
        end
    end
    for (int i = 0; i < game_pkg::N_INV; i++) begin
        if (ref_alive[i]) begin
            if (wall) begin
                if (!floor_hit) begin
                    ref_v[i] = ref_v[i] + game_pkg::DROP_STEP;
                end
            end else if (ref_right) begin
                ref_h[i] = ref_h[i] + spd;
            end else begin
                ref_h[i] = ref_h[i] - spd;
            end
        end
    end
    if (wall) begin
        ref_right = !ref_right;
    end
    for (int i = 0; i < game_pkg::N_INV; i++) begin
        if (!hit && ref_shot && ref_alive[i]
                && ref_shot_h >= ref_h[i] && ref_shot_h < ref_h[i] + game_pkg::INV_SIZE
                && ref_shot_v < ref_v[i] + game_pkg::INV_SIZE
                && ref_v[i] < ref_shot_v + game_pkg::LASER_LEN) begin
            ref_alive[i] = 1'b0;
            ref_shot = 1'b0;
            hit = 1'b1;
        end
    end
    if (left && ref_cannon >= game_pkg::CANNON_STEP) begin
        ref_cannon = ref_cannon - game_pkg::CANNON_STEP;
    end else if (right && ref_cannon < game_pkg::CANNON_MAX) begin
        ref_cannon = ref_cannon + game_pkg::CANNON_STEP;
    end
    if (ref_shot) begin
        if (ref_shot_v < game_pkg::LASER_STEP) begin
            ref_shot = 1'b0;
        end else begin
            ref_shot_v = ref_shot_v - game_pkg::LASER_STEP;
        end
    end else if (fire) begin
        ref_shot = 1'b1;
        ref_shot_v = game_pkg::CANNON_V - game_pkg::LASER_LEN;
        ref_shot_h = old_cannon + game_pkg::CANNON_W / 2;
    end
endfunction

// laser over cannon over invaders over background
function automatic game_pkg::color_t expected_color(input game_pkg::coord_t sh,
                                                    input game_pkg::coord_t sv);
    int h;
    int v;
    h = int'(sh);
    v = int'(sv);
    if (ref_shot && h == ref_shot_h && v >= ref_shot_v
            && v < ref_shot_v + game_pkg::LASER_LEN) begin
        return game_pkg::LASER_COLOR;
    end
    if (h >= ref_cannon && h < ref_cannon + game_pkg::CANNON_W
            && v >= game_pkg::CANNON_V && v < game_pkg::CANNON_V + game_pkg::CANNON_H) begin
        return game_pkg::CANNON_COLOR;
    end
    for (int i = 0; i < game_pkg::N_INV; i++) begin
        if (ref_alive[i] && h >= ref_h[i] && h < ref_h[i] + game_pkg::INV_SIZE
                && v >= ref_v[i] && v < ref_v[i] + game_pkg::INV_SIZE) begin
            return game_pkg::ROW_COLOR[i / 4];
        end
    end
    return game_pkg::BG_COLOR;
endfunction

`endif

//--- test/game_tb.sv
`timescale 1ns/1ps

module game_tb;

    localparam int N_FRAMES    = 60;
    localparam int N_SCANS     = 64;
    localparam int BUSY_CYCLES = 3 * game_pkg::N_INV + 1;
    localparam int WATCHDOG_NS = N_FRAMES * (BUSY_CYCLES + 80) * 40 * 2;

    logic             clk25M = 1'b0;
    logic             reset;
    logic             frame_tick;
    logic             btn_left;
    logic             btn_right;
    logic             btn_fire;
    game_pkg::speed_t speed;
    logic             scan_en;
    game_pkg::coord_t scan_h;
    game_pkg::coord_t scan_v;
    logic             busy;
    logic             pixel_en;
    game_pkg::color_t pixel_color;
    int               speed_val;

    `include "game_model.svh"

    game_top u_dut (
        .clk25M      (clk25M),
        .reset       (reset),
        .frame_tick  (frame_tick),
        .btn_left    (btn_left),
        .btn_right   (btn_right),
        .btn_fire    (btn_fire),
        .speed       (speed),
        .scan_en     (scan_en),
        .scan_h      (scan_h),
        .scan_v      (scan_v),
        .busy        (busy),
        .pixel_en    (pixel_en),
        .pixel_color (pixel_color)
    );

    bind game_top game_checker u_checker (
        .clk25M     (clk25M),
        .reset      (reset),
        .frame_tick (frame_tick),
        .busy       (busy),
        .scan_en    (scan_en),
        .pixel_en   (pixel_en)
    );

    always #20 clk25M = ~clk25M;

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("Done: errors found");
        $fatal(1, "stopped at first failure");
    endtask

    task automatic check_color(input string name, input game_pkg::color_t expected,
                               input game_pkg::color_t actual);
        if (actual !== expected) begin
            fail_run($sformatf("MISMATCH %s expected %h actual %h", name, expected, actual));
        end
    endtask

    task automatic check_busy(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            fail_run($sformatf("MISMATCH %s expected %b actual %b", name, expected, actual));
        end
    endtask

    task automatic check_latency(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            fail_run($sformatf("MISMATCH %s expected %b actual %b", name, expected, actual));
        end
    endtask

    // random spot, or near an object of the model
    task automatic pick_scan(input bit aimed, output game_pkg::coord_t h,
                             output game_pkg::coord_t v);
        int obj;
        int dh;
        int dv;
        obj = int'($urandom % (game_pkg::N_INV + 2));
        dh = int'($urandom % 20) - 2;
        dv = int'($urandom % 20) - 2;
        if (!aimed) begin
            h = game_pkg::coord_t'($urandom % game_pkg::FIELD_W);
            v = game_pkg::coord_t'($urandom % game_pkg::FIELD_H);
        end else if (obj < game_pkg::N_INV) begin
            h = game_pkg::coord_t'(ref_h[obj] + dh);
            v = game_pkg::coord_t'(ref_v[obj] + dv);
        end else if (obj == game_pkg::N_INV) begin
            h = game_pkg::coord_t'(ref_cannon + dh);
            v = game_pkg::coord_t'(game_pkg::CANNON_V + dv / 2);
        end else begin
            h = game_pkg::coord_t'(ref_shot_h + int'($urandom % 3) - 1);
            v = game_pkg::coord_t'(ref_shot_v + int'($urandom % 10) - 1);
        end
    endtask

    task automatic run_scans(input string name);
        game_pkg::coord_t h;
        game_pkg::coord_t v;
        game_pkg::color_t expect_q [$];
        logic             en_q [$];
        logic             en_exp;
        // scan_en was low before this burst
        for (int i = 0; i < game_pkg::PIXEL_LATENCY; i++) begin
            en_q.push_back(1'b0);
        end
        for (int i = 0; i < N_SCANS + game_pkg::PIXEL_LATENCY; i++) begin
            @(posedge clk25M);
            if (i < N_SCANS) begin
                pick_scan(i % 2 == 1, h, v);
                scan_en <= 1'b1;
                scan_h <= h;
                scan_v <= v;
                expect_q.push_back(expected_color(h, v));
                en_q.push_back(1'b1);
            end else begin
                scan_en <= 1'b0;
                en_q.push_back(1'b0);
            end
            @(negedge clk25M);
            en_exp = en_q.pop_front();
            check_latency($sformatf("%s cycle %0d pixel_en", name, i), en_exp, pixel_en);
            if (pixel_en) begin
                check_color($sformatf("%s cycle %0d colour", name, i),
                            expect_q.pop_front(), pixel_color);
            end
        end
    endtask

    task automatic run_frame(input int f);
        bit left;
        bit right;
        bit fire;
        bit extra;
        int k;
        left = ($urandom % 3) == 0;
        right = ($urandom % 2) == 0;
        fire = ($urandom % 2) == 0;
        // sometimes a second tick lands mid update
        extra = ($urandom % 4) == 0;
        @(posedge clk25M);
        btn_left <= left;
        btn_right <= right;
        btn_fire <= fire;
        frame_tick <= 1'b1;
        k = 0;
        do begin
            @(posedge clk25M);
            frame_tick <= extra && (k == 8);
            @(negedge clk25M);
            k++;
            check_busy($sformatf("frame %0d busy cycle %0d", f, k), (k <= BUSY_CYCLES), busy);
        end while (busy);
        step_frame(left, right, fire, speed_val);
    endtask

    initial begin
        #(WATCHDOG_NS);
        fail_run("timeout: the run did not finish before the watchdog expired");
    end

    initial begin
        void'($urandom(32'hef6f));
        speed_val = 1 + int'($urandom % 8);
        reset <= 1'b1;
        frame_tick <= 1'b0;
        btn_left <= 1'b0;
        btn_right <= 1'b0;
        btn_fire <= 1'b0;
        speed <= game_pkg::speed_t'(speed_val);
        scan_en <= 1'b0;
        scan_h <= '0;
        scan_v <= '0;
        reset_model();
        repeat (4) @(posedge clk25M);
        reset <= 1'b0;
        run_scans("reset picture");
        for (int f = 0; f < N_FRAMES; f++) begin
            run_frame(f);
            run_scans($sformatf("frame %0d", f));
        end
        $display("Done: no errors");
        $finish;
    end

endmodule

//--- sim.f
+incdir+test
design/game_pkg.sv
design/laser_if.sv
design/frame_sequencer.sv
design/invader_formation.sv
design/cannon_laser.sv
design/pixel_renderer.sv
design/game_top.sv
test/game_checker.sv
test/game_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module game_tb -f sim.f
./obj_dir/Vgame_tb
